// ==== list.f ====
design/lbp_pkg.sv
design/line_window.sv
design/bilinear_interp.sv
design/circle_sampler.sv
design/lbp_encoder.sv
design/lbp_top.sv
test/tb_lbp_top.sv

// ==== Makefile ====
.PHONY: all run_r1 run_r2 lint clean

all: run_r1 run_r2

run_r1:
	verilator --binary --timing --assert -GR=1 -f list.f --top-module tb_lbp_top -Mdir obj_r1
	@out=$$(./obj_r1/Vtb_lbp_top); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

run_r2:
	verilator --binary --timing --assert -GR=2 -f list.f --top-module tb_lbp_top -Mdir obj_r2
	@out=$$(./obj_r2/Vtb_lbp_top); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only -Wall --top-module lbp_top design/lbp_pkg.sv \
		design/line_window.sv design/bilinear_interp.sv design/circle_sampler.sv \
		design/lbp_encoder.sv design/lbp_top.sv

clean:
	rm -rf obj_r1 obj_r2

// ==== test/tb_lbp_top.sv ====
`timescale 1ns/1ps

module tb_lbp_top
    import lbp_pkg::*;
#(
    parameter int R = 2
);

    localparam int IMG_W      = 16;
    localparam int IMG_H      = 8;
    localparam int CLK_PERIOD = 100;
    localparam int LATENCY    = 4;
    localparam int PER_FRAME  = (IMG_W - 2*R) * (IMG_H - 2*R);

    // R=2 diagonal weights for f = sqrt(2) - 1 in 24 fraction bits
    localparam longint WT_NN = 5757030;
    localparam longint WT_NF = 4070835;
    localparam longint WT_FF = 2878516;

    // Steps for points 0 to 7 counter-clockwise from the right with rows growing down
    localparam int STEP_R [8] = '{0, -1, -1, -1, 0, 1, 1, 1};
    localparam int STEP_C [8] = '{1, 1, 0, -1, -1, -1, 0, 1};

    logic        clk = 1'b0;
    logic        rst;
    logic        pix_valid_i;
    logic        frame_start_i;
    pixel_t      pix_i;
    logic [7:0]  code_o;
    logic        code_valid_o;

    int          img [IMG_H][IMG_W];
    logic [7:0]  exp_code_q [$];
    int          exp_edge_q [$];
    logic [31:0] rng = 32'h9c908a87;
    int          cyc = 0;
    int          got_cnt = 0;
    int          err_cnt = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    lbp_top #(
        .R     (R),
        .IMG_W (IMG_W)
    ) u_lbp_top (
        .clk           (clk),
        .rst           (rst),
        .pix_valid_i   (pix_valid_i),
        .frame_start_i (frame_start_i),
        .pix_i         (pix_i),
        .code_o        (code_o),
        .code_valid_o  (code_valid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Point k of the circle around (y, x) in 8.24
    function automatic longint circle_sample(int y, int x, int k);
        int dr;
        int dc;
        dr = STEP_R[k];
        dc = STEP_C[k];
        if (dr == 0 || dc == 0) begin
            return longint'(img[y + R*dr][x + R*dc]) << 24;
        end
        if (R == 1) begin
            return longint'(img[y + dr][x + dc]) << 24;
        end
        // Near corner one step in and far corner two steps in
        return longint'(img[y + dr][x + dc]) * WT_NN
             + longint'(img[y + dr][x + 2*dc]) * WT_NF
             + longint'(img[y + 2*dr][x + dc]) * WT_NF
             + longint'(img[y + 2*dr][x + 2*dc]) * WT_FF;
    endfunction

    function automatic logic [7:0] model_code(int y, int x);
        logic [7:0] code;
        longint     centre;
        centre = longint'(img[y][x]) << 24;
        for (int k = 0; k < 8; k++) begin
            code[k] = (circle_sample(y, x, k) >= centre);
        end
        return code;
    endfunction

    // Mode 0 flat, 1 random, 2 ramp
    task automatic fill_image(input int mode, input int value);
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                img[y][x] = (mode == 1) ? int'(next_rand() >> 24) :
                            (mode == 2) ? (y * 29 + x * 13) % 256 : value;
            end
        end
    endtask

    // Streams rows y0 to y1 and starts a frame at row y0 when start is set
    task automatic stream_rows(input int y0, input int y1, input bit start, input int gap_max);
        int gap;
        for (int y = y0; y <= y1; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                @(posedge clk);
                pix_valid_i   <= 1'b1;
                frame_start_i <= start && (y == y0) && (x == 0);
                pix_i         <= pixel_t'(img[y][x]);
                if (start && (y - y0) >= 2*R && x >= 2*R) begin
                    exp_code_q.push_back(model_code(y - R, x - R));
                    // cyc still holds the count before this edge
                    exp_edge_q.push_back(cyc + 1 + LATENCY);
                end
                gap = (gap_max > 0) ? int'(next_rand() % 32'(gap_max + 1)) : 0;
                repeat (gap) begin
                    @(posedge clk);
                    pix_valid_i   <= 1'b0;
                    frame_start_i <= 1'b0;
                end
            end
        end
        @(posedge clk);
        pix_valid_i   <= 1'b0;
        frame_start_i <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int want_cnt, input int cnt_base,
                               input int err_base);
        int waited;
        waited = 0;
        while (exp_code_q.size() > 0 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_code_q.size() == 0) else begin
            err_cnt++;
            $display("Timed out with %0d codes still pending", exp_code_q.size());
        end
        // Idle a little so a stray code shows up
        repeat (2 * LATENCY) @(posedge clk);
        assert (got_cnt - cnt_base == want_cnt) else begin
            err_cnt++;
            $display("Received %0d codes, expected %0d", got_cnt - cnt_base, want_cnt);
        end
        if (err_cnt == err_base) begin
            n_pass++;
            $display("%-20s ok", name);
        end else begin
            n_fail++;
            $display("%-20s failed with %0d errors", name, err_cnt - err_base);
        end
    endtask

    task automatic test_flat();
        int cnt_base;
        int err_base;
        cnt_base = got_cnt;
        err_base = err_cnt;
        fill_image(0, 77);
        stream_rows(0, IMG_H - 1, 1'b1, 0);
        finish_test("flat image", PER_FRAME, cnt_base, err_base);
    endtask

    task automatic test_bright_spot();
        int cnt_base;
        int err_base;
        cnt_base = got_cnt;
        err_base = err_cnt;
        fill_image(0, 10);
        img[4][7] = 255;
        stream_rows(0, IMG_H - 1, 1'b1, 0);
        finish_test("bright spot", PER_FRAME, cnt_base, err_base);
    endtask

    task automatic test_random();
        int cnt_base;
        int err_base;
        cnt_base = got_cnt;
        err_base = err_cnt;
        for (int f = 0; f < 3; f++) begin
            fill_image(1, 0);
            stream_rows(0, IMG_H - 1, 1'b1, 0);
        end
        finish_test("random frames", 3 * PER_FRAME, cnt_base, err_base);
    endtask

    task automatic test_back_to_back();
        int cnt_base;
        int err_base;
        cnt_base = got_cnt;
        err_base = err_cnt;
        fill_image(2, 0);
        stream_rows(0, IMG_H - 1, 1'b1, 0);
        finish_test("back-to-back", PER_FRAME, cnt_base, err_base);
    endtask

    task automatic test_gapped_reframe();
        int cnt_base;
        int err_base;
        cnt_base = got_cnt;
        err_base = err_cnt;
        fill_image(1, 0);
        stream_rows(0, IMG_H - 1, 1'b1, 3);
        fill_image(1, 0);
        stream_rows(0, IMG_H - 1, 1'b1, 3);
        finish_test("gapped and reframed", 2 * PER_FRAME, cnt_base, err_base);
    endtask

    task automatic test_reset_mid_frame();
        int cnt_base;
        int err_base;
        err_base = err_cnt;
        fill_image(1, 0);
        stream_rows(0, 4, 1'b1, 0);
        // Codes still in the pipeline are lost
        rst <= 1'b1;
        exp_code_q.delete();
        exp_edge_q.delete();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cnt_base = got_cnt;
        // Rest of the old frame has no frame start
        stream_rows(5, IMG_H - 1, 1'b0, 0);
        stream_rows(0, IMG_H - 1, 1'b1, 0);
        finish_test("reset mid-frame", PER_FRAME, cnt_base, err_base);
    endtask

    // Codes compared mid-cycle away from the driving edge
    always @(negedge clk) begin : monitor
        logic [7:0] want_code;
        int         want_edge;
        if (!rst && code_valid_o) begin
            got_cnt++;
            assert (exp_code_q.size() > 0) else begin
                err_cnt++;
                $display("code_valid_o pulsed with no code pending on edge %0d", cyc);
            end
            if (exp_code_q.size() > 0) begin
                want_code = exp_code_q.pop_front();
                want_edge = exp_edge_q.pop_front();
                assert (code_o == want_code) else begin
                    err_cnt++;
                    $display("** Error: code_o = 0x%02h, expected 0x%02h", code_o, want_code);
                end
                assert (cyc == want_edge) else begin
                    err_cnt++;
                    $display("Code came on edge %0d instead of edge %0d", cyc, want_edge);
                end
            end
        end
    end

    initial begin
        rst           = 1'b1;
        pix_valid_i   = 1'b0;
        frame_start_i = 1'b0;
        pix_i         = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_flat();
        test_bright_spot();
        test_random();
        test_back_to_back();
        test_gapped_reframe();
        test_reset_mid_frame();
        $display("R=%0d: %0d tests passed, %0d failed, %0d errors", R, n_pass, n_fail, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== design/lbp_top.sv ====
`timescale 1ns/1ps

module lbp_top
    import lbp_pkg::*;
#(
    parameter int R     = 1,
    parameter int IMG_W = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       pix_valid_i,
    input  logic       frame_start_i,
    input  pixel_t     pix_i,
    output logic [7:0] code_o,
    output logic       code_valid_o
);

    pixel_t [(2*R+1)*(2*R+1)-1:0] win;
    logic                         win_valid;
    sample_t                      s0;
    sample_t                      s1;
    sample_t                      s2;
    sample_t                      s3;
    sample_t                      s4;
    sample_t                      s5;
    sample_t                      s6;
    sample_t                      s7;
    pixel_t                       center;
    logic                         samp_done;

    line_window #(
        .R     (R),
        .IMG_W (IMG_W)
    ) u_line_window (
        .clk           (clk),
        .rst           (rst),
        .pix_valid_i   (pix_valid_i),
        .frame_start_i (frame_start_i),
        .pix_i         (pix_i),
        .win_o         (win),
        .win_valid_o   (win_valid)
    );

    // Samples and centre arrive together two cycles after the window
    circle_sampler #(
        .R (R)
    ) u_circle_sampler (
        .clk         (clk),
        .rst         (rst),
        .win_i       (win),
        .win_valid_i (win_valid),
        .s0_o        (s0),
        .s1_o        (s1),
        .s2_o        (s2),
        .s3_o        (s3),
        .s4_o        (s4),
        .s5_o        (s5),
        .s6_o        (s6),
        .s7_o        (s7),
        .center_o    (center),
        .done_o      (samp_done)
    );

    lbp_encoder u_lbp_encoder (
        .clk          (clk),
        .rst          (rst),
        .s0_i         (s0),
        .s1_i         (s1),
        .s2_i         (s2),
        .s3_i         (s3),
        .s4_i         (s4),
        .s5_i         (s5),
        .s6_i         (s6),
        .s7_i         (s7),
        .center_i     (center),
        .done_i       (samp_done),
        .code_o       (code_o),
        .code_valid_o (code_valid_o)
    );

endmodule

// ==== design/lbp_encoder.sv ====
`timescale 1ns/1ps

module lbp_encoder
    import lbp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  sample_t    s0_i,
    input  sample_t    s1_i,
    input  sample_t    s2_i,
    input  sample_t    s3_i,
    input  sample_t    s4_i,
    input  sample_t    s5_i,
    input  sample_t    s6_i,
    input  sample_t    s7_i,
    input  pixel_t     center_i,
    input  logic       done_i,
    output logic [7:0] code_o,
    output logic       code_valid_o
);

    sample_t    center_s;
    logic [7:0] code_d;

    // Centre in 8.24 so it compares against interpolated samples
    assign center_s = {center_i, {FRAC_W{1'b0}}};

    // Equal counts as set
    always_comb begin
        code_d[0] = (s0_i >= center_s);
        code_d[1] = (s1_i >= center_s);
        code_d[2] = (s2_i >= center_s);
        code_d[3] = (s3_i >= center_s);
        code_d[4] = (s4_i >= center_s);
        code_d[5] = (s5_i >= center_s);
        code_d[6] = (s6_i >= center_s);
        code_d[7] = (s7_i >= center_s);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            code_valid_o <= 1'b0;
        end else begin
            code_valid_o <= done_i;
        end
    end

    always_ff @(posedge clk) begin
        code_o <= code_d;
    end

endmodule

// ==== design/circle_sampler.sv ====
`timescale 1ns/1ps

module circle_sampler
    import lbp_pkg::*;
#(
    parameter int R = 1
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  pixel_t [(2*R+1)*(2*R+1)-1:0]         win_i,
    input  logic                                 win_valid_i,
    output sample_t                              s0_o,
    output sample_t                              s1_o,
    output sample_t                              s2_o,
    output sample_t                              s3_o,
    output sample_t                              s4_o,
    output sample_t                              s5_o,
    output sample_t                              s6_o,
    output sample_t                              s7_o,
    output pixel_t                               center_o,
    output logic                                 done_o
);

    localparam int N = 2 * R + 1;

    // Axis points at 0, 90, 180, 270 degrees
    localparam int AX_ROW [4] = '{R, 0, R, 2*R};
    localparam int AX_COL [4] = '{2*R, R, 0, R};

    // Diagonal directions at 45, 135, 225, 315, row grows downwards
    localparam int DG_SR [4] = '{-1, -1, 1, 1};
    localparam int DG_SC [4] = '{1, -1, -1, 1};

    pixel_t [3:0] axis_d1;
    pixel_t [3:0] axis_d2;
    pixel_t       center_d1;
    logic   [1:0] valid_sr;
    sample_t      diag_s [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[0], win_valid_i};
        end
    end

    assign done_o = valid_sr[1];

    // Two-cycle delay to line up with the interpolators
    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            axis_d1[j] <= win_i[AX_ROW[j]*N + AX_COL[j]];
        end
        axis_d2   <= axis_d1;
        center_d1 <= win_i[R*N + R];
        center_o  <= center_d1;
    end

    assign s0_o = {axis_d2[0], {FRAC_W{1'b0}}};
    assign s2_o = {axis_d2[1], {FRAC_W{1'b0}}};
    assign s4_o = {axis_d2[2], {FRAC_W{1'b0}}};
    assign s6_o = {axis_d2[3], {FRAC_W{1'b0}}};

    assign s1_o = diag_s[0];
    assign s3_o = diag_s[1];
    assign s5_o = diag_s[2];
    assign s7_o = diag_s[3];

    if (R == 1) begin : g_direct
        pixel_t [3:0] diag_d1;
        pixel_t [3:0] diag_d2;

        // Diagonals land on window corners
        always_ff @(posedge clk) begin
            for (int j = 0; j < 4; j++) begin
                diag_d1[j] <= win_i[(R+DG_SR[j])*N + R + DG_SC[j]];
            end
            diag_d2 <= diag_d1;
        end

        for (genvar j = 0; j < 4; j++) begin : g_diag
            assign diag_s[j] = {diag_d2[j], {FRAC_W{1'b0}}};
        end
    end else begin : g_interp
        // Near, two mixed, then far corner
        for (genvar j = 0; j < 4; j++) begin : g_diag
            bilinear_interp u_interp (
                .clk      (clk),
                .rst      (rst),
                .a_i      (win_i[(R+DG_SR[j])*N + R + DG_SC[j]]),
                .b_i      (win_i[(R+DG_SR[j])*N + R + 2*DG_SC[j]]),
                .c_i      (win_i[(R+2*DG_SR[j])*N + R + DG_SC[j]]),
                .d_i      (win_i[(R+2*DG_SR[j])*N + R + 2*DG_SC[j]]),
                .sample_o (diag_s[j])
            );
        end
    end

endmodule

// ==== design/bilinear_interp.sv ====
`timescale 1ns/1ps

module bilinear_interp
    import lbp_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  pixel_t  a_i,
    input  pixel_t  b_i,
    input  pixel_t  c_i,
    input  pixel_t  d_i,
    output sample_t sample_o
);

    // Weighted corners, each fits 8.24 without loss
    sample_t prod_a_q;
    sample_t prod_b_q;
    sample_t prod_c_q;
    sample_t prod_d_q;

    // Stage one multiplies
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_a_q <= '0;
            prod_b_q <= '0;
            prod_c_q <= '0;
            prod_d_q <= '0;
        end else begin
            prod_a_q <= sample_t'(a_i) * sample_t'(W_NN);
            prod_b_q <= sample_t'(b_i) * sample_t'(W_NF);
            prod_c_q <= sample_t'(c_i) * sample_t'(W_NF);
            prod_d_q <= sample_t'(d_i) * sample_t'(W_FF);
        end
    end

    // Stage two sums, weights total 2^24 so no overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_o <= '0;
        end else begin
            sample_o <= prod_a_q + prod_b_q + prod_c_q + prod_d_q;
        end
    end

endmodule

// ==== design/line_window.sv ====
`timescale 1ns/1ps

module line_window
    import lbp_pkg::*;
#(
    parameter int R     = 1,
    parameter int IMG_W = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pix_valid_i,
    input  logic                                 frame_start_i,
    input  pixel_t                               pix_i,
    output pixel_t [(2*R+1)*(2*R+1)-1:0]         win_o,
    output logic                                 win_valid_o
);

    localparam int N     = 2 * R + 1;
    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(N);

    // Line k holds the row k+1 above the incoming one
    pixel_t             line_buf [2*R][IMG_W];
    pixel_t [N-1:0]     new_col;

    logic               start;
    logic [COL_W-1:0]   col_q;
    logic [COL_W-1:0]   col_cur;
    logic [ROW_W-1:0]   row_q;
    logic [ROW_W-1:0]   row_cur;
    logic               in_frame_q;
    logic               in_frame_cur;
    logic               col_last;
    logic               row_full;

    // First pixel of a frame sees zeroed counters
    always_comb begin
        start        = pix_valid_i && frame_start_i;
        col_cur      = start ? '0 : col_q;
        row_cur      = start ? '0 : row_q;
        in_frame_cur = start || in_frame_q;
        col_last     = (col_cur == COL_W'(IMG_W - 1));
        row_full     = (row_cur == ROW_W'(2 * R));
    end

    // Newest column, top row at index 0
    always_comb begin
        for (int r = 0; r < 2*R; r++) begin
            new_col[r] = line_buf[2*R-1-r][col_cur];
        end
        new_col[2*R] = pix_i;
    end

    // Row count saturates once enough lines are buffered
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q       <= '0;
            row_q       <= '0;
            in_frame_q  <= 1'b0;
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= pix_valid_i && in_frame_cur && row_full &&
                           (col_cur >= COL_W'(2 * R));
            if (pix_valid_i) begin
                in_frame_q <= in_frame_cur;
                col_q      <= col_last ? '0 : col_cur + 1'b1;
                row_q      <= (col_last && !row_full) ? row_cur + 1'b1 : row_cur;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid_i) begin
            line_buf[0][col_cur] <= pix_i;
            for (int k = 1; k < 2*R; k++) begin
                line_buf[k][col_cur] <= line_buf[k-1][col_cur];
            end
            // Shift window left, newest column enters on the right
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N-1; c++) begin
                    win_o[r*N+c] <= win_o[r*N+c+1];
                end
                win_o[r*N+N-1] <= new_col[r];
            end
        end
    end

endmodule

// ==== design/lbp_pkg.sv ====
package lbp_pkg;

    // Grey pixel and 8.24 sample widths
    localparam int PIX_W  = 8;
    localparam int FRAC_W = 24;
    localparam int SAMP_W = PIX_W + FRAC_W;

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [SAMP_W-1:0] sample_t;

    // Bilinear weights for a diagonal point at R=2
    // Fractional offset f = sqrt(2) - 1 towards the far corner

    // Mixed corners, f(1-f)
    localparam logic [FRAC_W-1:0] W_NF = 24'd4070835;

    // Far corner, f squared
    localparam logic [FRAC_W-1:0] W_FF = 24'd2878516;

    // Near corner takes the remainder so the four sum to 2^24
    localparam logic [FRAC_W-1:0] W_NN = 24'd5757030;

endpackage
